//--- compile.f
+incdir+rtl
rtl/adc_chan_pkg.sv
rtl/adc_data_format.sv
rtl/adc_pn_monitor.sv
rtl/adc_chan_regs.sv
rtl/adc_channel.sv
verification/adc_channel_chk.sv
verification/adc_channel_tb.sv

//--- rtl/adc_chan_defs.svh
// Shared widths, register map and PN codes; register addresses assume a 4-bit word address
`ifndef ADC_CHAN_DEFS_SVH
`define ADC_CHAN_DEFS_SVH

// **************************************************
// Data path widths
// **************************************************

// One converter sample as it arrives from the ADC
`define ADC_SAMPLE_W 14
// One formatted lane handed to the downstream logic
`define ADC_LANE_W 16

// **************************************************
// Register map
// **************************************************

// Word address width of the register bus
`define ADC_REG_AW 4
`define ADC_REG_CTRL 4'd0
`define ADC_REG_STATUS 4'd1
`define ADC_REG_ID 4'd2

// **************************************************
// PN monitor
// **************************************************

// Selector codes, every other code turns the check off
`define ADC_PN9 4'd0
`define ADC_PN23 4'd1
// Run length that enters or leaves the out-of-sync state
`define ADC_PN_OOS_CNT 16

`endif

//--- rtl/adc_chan_pkg.sv
// Channel types; the register word is 32 bits and both views keep their fields in the low bits
`default_nettype none

`include "adc_chan_defs.svh"

package adc_chan_pkg;

  // Two converter samples taken in one adc_clk cycle
  // Sample 0 sits in the low half of the word
  typedef struct packed {
    logic [`ADC_SAMPLE_W-1:0] s1;
    logic [`ADC_SAMPLE_W-1:0] s0;
  } adc_pair_t;

  // The two formatted lanes, lane 0 again in the low half
  typedef struct packed {
    logic [`ADC_LANE_W-1:0] lane1;
    logic [`ADC_LANE_W-1:0] lane0;
  } adc_fmt_t;

  // Control fields, enable ends up in bit 0 of the CTRL register
  typedef struct packed {
    logic [3:0] pnseq_sel;
    logic       dfmt_enable;
    logic       dfmt_type;
    logic       dfmt_se;
    logic       enable;
  } adc_ctrl_t;

  // Status bits, pn_err ends up in bit 0 of the STATUS register
  typedef struct packed {
    logic over_range;
    logic pn_oos;
    logic pn_err;
  } adc_status_t;

  // One register word decoded by address
  // CTRL uses the ctrl view, STATUS the status view and ID the raw word
  typedef union packed {
    struct packed {
      logic [31-$bits(adc_ctrl_t):0] pad;
      adc_ctrl_t                     fields;
    } ctrl;
    struct packed {
      logic [31-$bits(adc_status_t):0] pad;
      adc_status_t                     fields;
    } status;
    logic [31:0] word;
  } adc_reg_u;

endpackage

`default_nettype wire

//--- rtl/adc_chan_regs.sv
// Registers on adc_clk; a request must be a single-cycle pulse and unmapped addresses read zero
`timescale 1ns/10ps
`default_nettype none

`include "adc_chan_defs.svh"

module adc_chan_regs
  import adc_chan_pkg::*;
#(
  parameter int CHANNEL_ID = 0
) (
  input  logic                   adc_clk,
  input  logic                   arst_n,
  // Register bus
  input  logic                   reg_wreq,
  input  logic [`ADC_REG_AW-1:0] reg_waddr,
  input  logic [31:0]            reg_wdata,
  output logic                   reg_wack,
  input  logic                   reg_rreq,
  input  logic [`ADC_REG_AW-1:0] reg_raddr,
  output logic [31:0]            reg_rdata,
  output logic                   reg_rack,
  // Channel side
  output adc_ctrl_t              ctrl,
  input  logic                   pn_err,
  input  logic                   pn_oos,
  input  logic                   adc_or
);

  adc_ctrl_t ctrl_q;
  // Sticky status, set by events and cleared by writing 1
  logic      err_sticky;
  logic      or_sticky;
  // Write word and read word seen through the register union
  adc_reg_u  wr_word;
  adc_reg_u  rd_word;
  logic      wr_ctrl;
  logic      wr_status;
  logic      clr_err;
  logic      clr_or;

  // **************************************************
  // Write side
  // **************************************************

  always_comb begin
    wr_word.word = reg_wdata;
  end

  assign wr_ctrl = reg_wreq && (reg_waddr == `ADC_REG_CTRL);
  assign wr_status = reg_wreq && (reg_waddr == `ADC_REG_STATUS);
  assign clr_err = wr_status & wr_word.status.fields.pn_err;
  assign clr_or = wr_status & wr_word.status.fields.over_range;

  // The write lands on the same edge that raises the acknowledge
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_wack <= 1'b0;
      ctrl_q <= '0;
    end else begin
      reg_wack <= reg_wreq;
      if (wr_ctrl) begin
        ctrl_q <= wr_word.ctrl.fields;
      end
    end
  end

  // A new event in the clearing cycle keeps the bit set
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      err_sticky <= 1'b0;
      or_sticky <= 1'b0;
    end else begin
      err_sticky <= (err_sticky & ~clr_err) | pn_err;
      or_sticky <= (or_sticky & ~clr_or) | adc_or;
    end
  end

  assign ctrl = ctrl_q;

  // **************************************************
  // Read side
  // **************************************************

  // pn_oos is read live, the other two status bits are sticky
  always_comb begin
    rd_word.word = '0;
    case (reg_raddr)
      `ADC_REG_CTRL: begin
        rd_word.ctrl.fields = ctrl_q;
      end
      `ADC_REG_STATUS: begin
        rd_word.status.fields.pn_err = err_sticky;
        rd_word.status.fields.pn_oos = pn_oos;
        rd_word.status.fields.over_range = or_sticky;
      end
      `ADC_REG_ID: begin
        rd_word.word = 32'(CHANNEL_ID);
      end
      default: begin
        rd_word.word = '0;
      end
    endcase
  end

  // Read data is only non-zero in the acknowledge cycle
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_rack <= 1'b0;
      reg_rdata <= '0;
    end else begin
      reg_rack <= reg_rreq;
      reg_rdata <= reg_rreq ? rd_word.word : '0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/adc_channel.sv
// Single receive channel, all logic on adc_clk; data streams every cycle with no back-pressure
`timescale 1ns/10ps
`default_nettype none

`include "adc_chan_defs.svh"

module adc_channel
  import adc_chan_pkg::*;
#(
  parameter int CHANNEL_ID = 0
) (
  input  logic                   adc_clk,
  input  logic                   arst_n,
  // Converter side
  input  adc_pair_t              adc_data,
  input  logic                   adc_data_valid,
  input  logic                   adc_or,
  // Formatted output
  output adc_fmt_t               adc_dfmt_data,
  output logic                   adc_valid,
  output logic                   adc_enable,
  // Register bus
  input  logic                   reg_wreq,
  input  logic [`ADC_REG_AW-1:0] reg_waddr,
  input  logic [31:0]            reg_wdata,
  output logic                   reg_wack,
  input  logic                   reg_rreq,
  input  logic [`ADC_REG_AW-1:0] reg_raddr,
  output logic [31:0]            reg_rdata,
  output logic                   reg_rack
);

  // Control fields from the register block to both stages
  adc_ctrl_t ctrl;
  // PN monitor results for the status register
  logic      pn_err;
  logic      pn_oos;

  // Format stage on the main data path
  adc_data_format u_format (
    .adc_clk    (adc_clk),
    .arst_n     (arst_n),
    .data_in    (adc_data),
    .data_valid (adc_data_valid),
    .ctrl       (ctrl),
    .data_out   (adc_dfmt_data),
    .valid_out  (adc_valid)
  );

  // The PN check sees the raw samples, not the formatted lanes
  adc_pn_monitor u_pn (
    .adc_clk   (adc_clk),
    .arst_n    (arst_n),
    .data_in   (adc_data),
    .pnseq_sel (ctrl.pnseq_sel),
    .pn_err    (pn_err),
    .pn_oos    (pn_oos)
  );

  adc_chan_regs #(
    .CHANNEL_ID (CHANNEL_ID)
  ) u_regs (
    .adc_clk   (adc_clk),
    .arst_n    (arst_n),
    .reg_wreq  (reg_wreq),
    .reg_waddr (reg_waddr),
    .reg_wdata (reg_wdata),
    .reg_wack  (reg_wack),
    .reg_rreq  (reg_rreq),
    .reg_raddr (reg_raddr),
    .reg_rdata (reg_rdata),
    .reg_rack  (reg_rack),
    .ctrl      (ctrl),
    .pn_err    (pn_err),
    .pn_oos    (pn_oos),
    .adc_or    (adc_or)
  );

  assign adc_enable = ctrl.enable;

endmodule

`default_nettype wire

//--- rtl/adc_data_format.sv
// One cycle of latency for data and valid; the control fields are applied without any delay
`timescale 1ns/10ps
`default_nettype none

`include "adc_chan_defs.svh"

module adc_data_format
  import adc_chan_pkg::*;
(
  input  logic      adc_clk,
  input  logic      arst_n,
  input  adc_pair_t data_in,
  input  logic      data_valid,
  input  adc_ctrl_t ctrl,
  output adc_fmt_t  data_out,
  output logic      valid_out
);

  // Both lanes after the format rule, before the output register
  adc_fmt_t fmt_d;

  // Formats one sample into one lane
  // With formatting off the sample is only zero-extended
  // The MSB flip turns offset binary into two's complement
  function automatic logic [`ADC_LANE_W-1:0] fmt_lane(
    input logic [`ADC_SAMPLE_W-1:0] smp,
    input adc_ctrl_t                c
  );
    logic [`ADC_SAMPLE_W-1:0] s;
    logic                     ext;
    s = smp;
    ext = 1'b0;
    if (c.dfmt_enable) begin
      s[`ADC_SAMPLE_W-1] = smp[`ADC_SAMPLE_W-1] ^ c.dfmt_type;
      // Sign extension copies the (possibly flipped) bit 13
      ext = c.dfmt_se & s[`ADC_SAMPLE_W-1];
    end
    return {{(`ADC_LANE_W-`ADC_SAMPLE_W){ext}}, s};
  endfunction

  // Both samples share the same rule and the same control fields
  always_comb begin
    fmt_d.lane0 = fmt_lane(data_in.s0, ctrl);
    fmt_d.lane1 = fmt_lane(data_in.s1, ctrl);
  end

  // Output data register
  always_ff @(posedge adc_clk) begin
    data_out <= fmt_d;
  end

  // Valid follows the input strobe one cycle later
  // A disabled channel never raises valid
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= data_valid & ctrl.enable;
    end
  end

endmodule

`default_nettype wire

//--- rtl/adc_pn_monitor.sv
// Self-seeding PN check with two cycles of latency; bit 27 of {s1,s0} is the oldest stream bit
`timescale 1ns/10ps
`default_nettype none

`include "adc_chan_defs.svh"

module adc_pn_monitor
  import adc_chan_pkg::*;
(
  input  logic       adc_clk,
  input  logic       arst_n,
  input  adc_pair_t  data_in,
  input  logic [3:0] pnseq_sel,
  output logic       pn_err,
  output logic       pn_oos
);

  localparam int WORD_W = 2 * `ADC_SAMPLE_W;
  localparam int CNT_W = $clog2(`ADC_PN_OOS_CNT);

  // Stage one holds the newest word and the prediction for it
  logic [WORD_W-1:0] word_q;
  logic [WORD_W-1:0] pred_q;
  // Length of the current run of words that disagree with pn_oos
  logic [CNT_W-1:0]  run_cnt;
  logic              sel_ok;
  logic              mismatch;
  logic              run_evt;
  logic              run_done;

  // **************************************************
  // Sequence prediction
  // **************************************************

  // Runs the selected LFSR for one word, seeded from the newest bits of w
  // PN9 feeds back from stages 9 and 5, PN23 from stages 23 and 18
  // st[k] holds the stream bit that is k+1 bits older than the next one
  function automatic logic [WORD_W-1:0] pn_next(
    input logic [WORD_W-1:0] w,
    input logic [3:0]        sel
  );
    logic [22:0]       st;
    logic              fb;
    logic [WORD_W-1:0] nxt;
    st = w[22:0];
    nxt = '0;
    for (int i = WORD_W - 1; i >= 0; i--) begin
      if (sel == `ADC_PN23) begin
        fb = st[22] ^ st[17];
      end else begin
        fb = st[8] ^ st[4];
      end
      st = {st[21:0], fb};
      nxt[i] = fb;
    end
    return nxt;
  endfunction

  assign sel_ok = (pnseq_sel == `ADC_PN9) || (pnseq_sel == `ADC_PN23);

  // Stage one, the prediction is built from the word that came before
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      word_q <= '0;
      pred_q <= '0;
    end else begin
      word_q <= data_in;
      pred_q <= pn_next(word_q, pnseq_sel);
    end
  end

  // **************************************************
  // Compare and sync tracking
  // **************************************************

  assign mismatch = (word_q != pred_q);
  // Matches count while out of sync, mismatches count while in sync
  assign run_evt = mismatch ^ pn_oos;
  assign run_done = (run_cnt == CNT_W'(`ADC_PN_OOS_CNT - 1));

  // Stage two
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      pn_oos <= 1'b1;
      pn_err <= 1'b0;
      run_cnt <= '0;
    end else if (!sel_ok) begin
      // No sequence selected, so the monitor stays out of sync
      pn_oos <= 1'b1;
      pn_err <= 1'b0;
      run_cnt <= '0;
    end else begin
      // Errors are only reported once the stream has locked
      pn_err <= mismatch & ~pn_oos;
      if (run_evt) begin
        if (run_done) begin
          pn_oos <= ~pn_oos;
          run_cnt <= '0;
        end else begin
          run_cnt <= run_cnt + CNT_W'(1);
        end
      end else begin
        // One word that agrees with the state breaks the run
        run_cnt <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds the channel testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=adc_channel_sim

verilator --binary --timing --assert \
  -f compile.f \
  --top-module adc_channel_tb \
  -o "$BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/"$BIN" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1

//--- verification/adc_channel_chk.sv
// Checker bound into adc_channel; it tracks CTRL from the register bus, so writes must use address 0
`timescale 1ns/10ps
`default_nettype none

`include "adc_chan_defs.svh"

module adc_channel_chk
  import adc_chan_pkg::*;
(
  input logic                   adc_clk,
  input logic                   arst_n,
  input adc_pair_t              adc_data,
  input logic                   adc_data_valid,
  input adc_fmt_t               adc_dfmt_data,
  input logic                   adc_valid,
  input logic                   adc_enable,
  input logic                   reg_wreq,
  input logic [`ADC_REG_AW-1:0] reg_waddr,
  input logic [31:0]            reg_wdata,
  input logic                   reg_wack,
  input logic                   reg_rreq,
  input logic [31:0]            reg_rdata,
  input logic                   reg_rack
);

  // Read by the testbench at the end of the run
  int        fail_cnt = 0;
  // Copy of the control register, rebuilt from the bus writes
  adc_ctrl_t shadow;
  adc_reg_u  wr;
  adc_fmt_t  exp_fmt;
  logic      exp_valid;
  logic      wreq_q;
  logic      rreq_q;
  // Set one cycle after reset release, once every model flop holds real history
  logic      past_ok;

  // Expected lane: optional MSB flip, then sign or zero extension
  function automatic logic [`ADC_LANE_W-1:0] lane_exp(
    input logic [`ADC_SAMPLE_W-1:0] s,
    input adc_ctrl_t                c
  );
    logic msb;
    msb = s[`ADC_SAMPLE_W-1] ^ (c.dfmt_enable & c.dfmt_type);
    if (c.dfmt_enable && c.dfmt_se) begin
      return {{2{msb}}, msb, s[`ADC_SAMPLE_W-2:0]};
    end
    return {2'b00, msb, s[`ADC_SAMPLE_W-2:0]};
  endfunction

  always_comb begin
    wr.word = reg_wdata;
  end

  // **************************************************
  // Reference model
  // **************************************************

  // These flops switch on the same edges as the DUT flops they model
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      shadow <= '0;
      exp_fmt <= '0;
      exp_valid <= 1'b0;
      wreq_q <= 1'b0;
      rreq_q <= 1'b0;
      past_ok <= 1'b0;
    end else begin
      if (reg_wreq && (reg_waddr == `ADC_REG_CTRL)) begin
        shadow <= wr.ctrl.fields;
      end
      exp_fmt <= {lane_exp(adc_data.s1, shadow), lane_exp(adc_data.s0, shadow)};
      exp_valid <= adc_data_valid & shadow.enable;
      wreq_q <= reg_wreq;
      rreq_q <= reg_rreq;
      past_ok <= 1'b1;
    end
  end

  // **************************************************
  // Assertions
  // **************************************************

  // Nothing on the outputs may be active while reset is held
  a_reset_outputs: assert property (@(posedge adc_clk)
    !arst_n |-> (!adc_valid && !adc_enable && !reg_wack && !reg_rack && (reg_rdata == '0)))
    else begin
      $error("Outputs not idle during reset");
      fail_cnt++;
    end

  a_wack_timing: assert property (@(posedge adc_clk) disable iff (!arst_n)
    past_ok |-> (reg_wack == wreq_q))
    else begin
      $error("reg_wack is %0b, expected %0b", reg_wack, wreq_q);
      fail_cnt++;
    end

  a_rack_timing: assert property (@(posedge adc_clk) disable iff (!arst_n)
    past_ok |-> (reg_rack == rreq_q))
    else begin
      $error("reg_rack is %0b, expected %0b", reg_rack, rreq_q);
      fail_cnt++;
    end

  // Read data stays zero outside the acknowledge cycle
  a_rdata_idle: assert property (@(posedge adc_clk) disable iff (!arst_n)
    !reg_rack |-> (reg_rdata == '0))
    else begin
      $error("reg_rdata is 0x%08h without reg_rack", reg_rdata);
      fail_cnt++;
    end

  a_format: assert property (@(posedge adc_clk) disable iff (!arst_n)
    past_ok |-> (adc_dfmt_data == exp_fmt))
    else begin
      $error("adc_dfmt_data is 0x%08h, expected 0x%08h", adc_dfmt_data, exp_fmt);
      fail_cnt++;
    end

  a_valid: assert property (@(posedge adc_clk) disable iff (!arst_n)
    past_ok |-> (adc_valid == exp_valid))
    else begin
      $error("adc_valid is %0b, expected %0b", adc_valid, exp_valid);
      fail_cnt++;
    end

  a_enable: assert property (@(posedge adc_clk) disable iff (!arst_n)
    adc_enable == shadow.enable)
    else begin
      $error("adc_enable is %0b, expected %0b", adc_enable, shadow.enable);
      fail_cnt++;
    end

endmodule

`default_nettype wire

//--- verification/adc_channel_tb.sv
// Testbench for one channel with ID 3; format and timing checks live in the bound checker
`timescale 1ns/10ps
`default_nettype none

`include "adc_chan_defs.svh"

module adc_channel_tb
  import adc_chan_pkg::*;
();

  localparam int MAX_CYCLES = 2000;
  localparam int ACK_LIMIT = 8;
  localparam logic [31:0] SEED = 32'h8d63;

  logic                   adc_clk;
  logic                   arst_n;
  adc_pair_t              adc_data;
  logic                   adc_data_valid;
  logic                   adc_or;
  adc_fmt_t               adc_dfmt_data;
  logic                   adc_valid;
  logic                   adc_enable;
  logic                   reg_wreq;
  logic [`ADC_REG_AW-1:0] reg_waddr;
  logic [31:0]            reg_wdata;
  logic                   reg_wack;
  logic                   reg_rreq;
  logic [`ADC_REG_AW-1:0] reg_raddr;
  logic [31:0]            reg_rdata;
  logic                   reg_rack;

  // Stream source: random words, or a PN9/PN23 sequence with an optional bad word
  logic                   stream_pn;
  logic                   pn23_mode;
  logic                   corrupt;
  // History of the generated bit stream, bit 0 is the newest bit
  logic [22:0]            pn_hist;
  logic [27:0]            pn_word;
  logic                   fb;
  logic [31:0]            rnd_data;
  logic [31:0]            rnd;
  logic [31:0]            rdata;
  int                     err_cnt;
  int                     cyc;

  adc_channel #(
    .CHANNEL_ID (3)
  ) u_dut (
    .adc_clk        (adc_clk),
    .arst_n         (arst_n),
    .adc_data       (adc_data),
    .adc_data_valid (adc_data_valid),
    .adc_or         (adc_or),
    .adc_dfmt_data  (adc_dfmt_data),
    .adc_valid      (adc_valid),
    .adc_enable     (adc_enable),
    .reg_wreq       (reg_wreq),
    .reg_waddr      (reg_waddr),
    .reg_wdata      (reg_wdata),
    .reg_wack       (reg_wack),
    .reg_rreq       (reg_rreq),
    .reg_raddr      (reg_raddr),
    .reg_rdata      (reg_rdata),
    .reg_rack       (reg_rack)
  );

  bind adc_channel adc_channel_chk u_chk (
    .adc_clk        (adc_clk),
    .arst_n         (arst_n),
    .adc_data       (adc_data),
    .adc_data_valid (adc_data_valid),
    .adc_dfmt_data  (adc_dfmt_data),
    .adc_valid      (adc_valid),
    .adc_enable     (adc_enable),
    .reg_wreq       (reg_wreq),
    .reg_waddr      (reg_waddr),
    .reg_wdata      (reg_wdata),
    .reg_wack       (reg_wack),
    .reg_rreq       (reg_rreq),
    .reg_rdata      (reg_rdata),
    .reg_rack       (reg_rack)
  );

  always #50 adc_clk = ~adc_clk;

  // **************************************************
  // Data source
  // **************************************************

  // PN9 taps the bits 9 and 5 back, PN23 the bits 23 and 18 back
  // The oldest bit of each word goes out in bit 27
  always @(posedge adc_clk) begin
    rnd_data = $urandom;
    if (stream_pn) begin
      for (int i = 27; i >= 0; i--) begin
        fb = pn23_mode ? (pn_hist[22] ^ pn_hist[17]) : (pn_hist[8] ^ pn_hist[4]);
        pn_hist = {pn_hist[21:0], fb};
        pn_word[i] = fb;
      end
      // The flipped bit only touches the output, the generator runs on
      pn_word[0] = pn_word[0] ^ corrupt;
      adc_data <= pn_word;
    end else begin
      adc_data <= rnd_data[27:0];
    end
    adc_data_valid <= rnd_data[31];
  end

  // Run limit, well above the length of all tests
  always @(posedge adc_clk) begin
    cyc++;
    if (cyc == MAX_CYCLES) begin
      $display("Run stopped at %0t after %0d cycles without finishing the tests", $time, cyc);
      $display("Simulation failed");
      $finish;
    end
  end

  // **************************************************
  // Register bus tasks
  // **************************************************

  function automatic logic [31:0] ctrl_word(input logic [3:0] sel, input logic [2:0] fmt,
                                            input logic en);
    return {24'd0, sel, fmt, en};
  endfunction

  task automatic run_cycles(input int n);
    repeat (n) @(posedge adc_clk);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // One-cycle request, then wait on the falling edge for the acknowledge
  task automatic write_reg(input logic [`ADC_REG_AW-1:0] addr, input logic [31:0] data);
    int n;
    @(posedge adc_clk);
    reg_wreq <= 1'b1;
    reg_waddr <= addr;
    reg_wdata <= data;
    @(posedge adc_clk);
    reg_wreq <= 1'b0;
    n = 0;
    @(negedge adc_clk);
    while (!reg_wack && n < ACK_LIMIT) begin
      @(negedge adc_clk);
      n++;
    end
    if (!reg_wack) begin
      $display("Write to address %0d at %0t was never acknowledged", addr, $time);
      err_cnt++;
    end
  endtask

  task automatic read_reg(input logic [`ADC_REG_AW-1:0] addr, output logic [31:0] data);
    int n;
    @(posedge adc_clk);
    reg_rreq <= 1'b1;
    reg_raddr <= addr;
    @(posedge adc_clk);
    reg_rreq <= 1'b0;
    n = 0;
    @(negedge adc_clk);
    while (!reg_rack && n < ACK_LIMIT) begin
      @(negedge adc_clk);
      n++;
    end
    if (!reg_rack) begin
      $display("Read of address %0d at %0t was never acknowledged", addr, $time);
      err_cnt++;
    end
    data = reg_rdata;
  endtask

  // STATUS holds pn_err in bit 0, pn_oos in bit 1 and over_range in bit 2
  task automatic check_status(input logic [31:0] exp);
    logic [31:0] st;
    read_reg(`ADC_REG_STATUS, st);
    check_value("STATUS", st, exp);
  endtask

  // **************************************************
  // Test sequence
  // **************************************************

  initial begin
    void'($urandom(SEED));
    adc_clk = 1'b0;
    arst_n = 1'b1;
    adc_data = '0;
    adc_data_valid = 1'b0;
    adc_or = 1'b0;
    reg_wreq = 1'b0;
    reg_waddr = '0;
    reg_wdata = '0;
    reg_rreq = 1'b0;
    reg_raddr = '0;
    stream_pn = 1'b0;
    pn23_mode = 1'b0;
    corrupt = 1'b0;
    pn_hist = '1;
    err_cnt = 0;
    cyc = 0;
    #1;
    arst_n = 1'b0;
    run_cycles(2);
    arst_n <= 1'b1;
    run_cycles(2);

    // Random CTRL values read back through the low byte
    for (int k = 0; k < 4; k++) begin
      rnd = $urandom;
      write_reg(`ADC_REG_CTRL, rnd);
      check_value("adc_enable", 32'(adc_enable), 32'(rnd[0]));
      read_reg(`ADC_REG_CTRL, rdata);
      check_value("CTRL", rdata, rnd & 32'h0000_00ff);
    end
    read_reg(`ADC_REG_ID, rdata);
    check_value("ID", rdata, 32'd3);

    // All eight format settings with the channel enabled
    for (int cfg = 0; cfg < 8; cfg++) begin
      write_reg(`ADC_REG_CTRL, ctrl_word(4'd0, 3'(cfg), 1'b1));
      run_cycles(60);
    end

    // Disabled channel, valid must stay low
    write_reg(`ADC_REG_CTRL, ctrl_word(`ADC_PN9, 3'b000, 1'b0));
    check_value("adc_enable", 32'(adc_enable), 32'd0);
    run_cycles(40);

    // PN9 lock
    write_reg(`ADC_REG_CTRL, ctrl_word(`ADC_PN9, 3'b000, 1'b1));
    stream_pn <= 1'b1;
    run_cycles(60);
    check_status(32'h0);

    // Park the selector on an unused code while the stream moves to PN23
    write_reg(`ADC_REG_CTRL, ctrl_word(4'hf, 3'b000, 1'b1));
    pn23_mode <= 1'b1;
    run_cycles(2);
    write_reg(`ADC_REG_CTRL, ctrl_word(`ADC_PN23, 3'b000, 1'b1));
    run_cycles(60);
    check_status(32'h0);

    // One bad word keeps the lock but sets the sticky error
    @(posedge adc_clk);
    corrupt <= 1'b1;
    @(posedge adc_clk);
    corrupt <= 1'b0;
    run_cycles(8);
    check_status(32'h1);
    write_reg(`ADC_REG_STATUS, 32'h1);
    check_status(32'h0);

    // Random words break the lock
    stream_pn <= 1'b0;
    run_cycles(60);
    check_status(32'h3);
    write_reg(`ADC_REG_STATUS, 32'h1);
    check_status(32'h2);

    // Over-range pulse
    @(posedge adc_clk);
    adc_or <= 1'b1;
    @(posedge adc_clk);
    adc_or <= 1'b0;
    run_cycles(2);
    check_status(32'h6);
    write_reg(`ADC_REG_STATUS, 32'h4);
    check_status(32'h2);
    run_cycles(4);

    $display("Register check errors: %0d, assertion failures: %0d", err_cnt,
             u_dut.u_chk.fail_cnt);
    if (err_cnt == 0 && u_dut.u_chk.fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
